// File: hw/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data path and address width
`define XLEN 32

// Register number width
`define REG_ADDR_W 5

// Architectural register count
`define NUM_REGS 32

// Major opcode field width
`define OPCODE_W 7

// First fetch address after reset
`define RESET_PC 0

// Sequential PC step
`define INSN_BYTES 4

`endif

// File: hw/rv_pkg.sv
`include "rv_defines.svh"

package rv_pkg;

  // RV32 major opcodes, bits [6:0] of the instruction
  typedef enum logic [`OPCODE_W-1:0] {
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_BRANCH   = 7'b1100011,
    OPC_JALR     = 7'b1100111,
    OPC_MISC_MEM = 7'b0001111,
    OPC_JAL      = 7'b1101111,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP       = 7'b0110011,
    OPC_SYSTEM   = 7'b1110011,
    OPC_AUIPC    = 7'b0010111,
    OPC_LUI      = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // Next-PC selection, nine cases so four bits
  typedef enum logic [3:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU,
    BR_JUMP,     // JAL, PC relative
    BR_JUMP_REG  // JALR, rs1 relative
  } branch_cond_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LINK,
    WB_IMM
  } wb_sel_e;

endpackage

// File: hw/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_decoder
  import rv_pkg::*;
(
  input  logic [`XLEN-1:0]       i_insn,
  input  logic                   i_halted,
  output logic [`REG_ADDR_W-1:0] o_rs1,
  output logic [`REG_ADDR_W-1:0] o_rs2,
  output logic [`REG_ADDR_W-1:0] o_rd,
  output logic [`XLEN-1:0]       o_imm,
  output alu_op_e                o_alu_op,
  output logic                   o_src_b_imm,
  output logic                   o_src_a_pc,
  output branch_cond_e           o_branch,
  output wb_sel_e                o_wb_sel,
  output logic                   o_wb_en,
  output logic                   o_halt_req,
  output logic                   o_illegal
);

  opcode_e          opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] imm_u;
  logic             writes_rd;
  logic             bad_insn;

  assign opcode = opcode_e'(i_insn[`OPCODE_W-1:0]);
  assign funct3 = i_insn[14:12];
  assign funct7 = i_insn[31:25];
  assign o_rd   = i_insn[11:7];
  assign o_rs1  = i_insn[19:15];
  assign o_rs2  = i_insn[24:20];

  // Sign-extended immediates, bit 31 is always the sign
  assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  assign imm_b = {{20{i_insn[31]}}, i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
  assign imm_j = {{12{i_insn[31]}}, i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};
  assign imm_u = {i_insn[31:12], 12'b0};

  always_comb begin
    o_imm       = imm_i;
    o_alu_op    = ALU_ADD;
    o_src_b_imm = 1'b0;
    o_src_a_pc  = 1'b0;
    o_branch    = BR_NONE;
    o_wb_sel    = WB_ALU;
    o_halt_req  = 1'b0;
    writes_rd   = 1'b0;
    bad_insn    = 1'b0;

    case (opcode)
      OPC_LUI: begin
        o_imm     = imm_u;
        o_wb_sel  = WB_IMM;
        writes_rd = 1'b1;
      end
      OPC_AUIPC: begin
        o_imm       = imm_u;
        o_src_a_pc  = 1'b1; // PC plus upper immediate
        o_src_b_imm = 1'b1;
        writes_rd   = 1'b1;
      end
      OPC_JAL: begin
        o_imm     = imm_j;
        o_branch  = BR_JUMP;
        o_wb_sel  = WB_LINK;
        writes_rd = 1'b1;
      end
      OPC_JALR: begin
        o_branch  = BR_JUMP_REG;
        o_wb_sel  = WB_LINK;
        writes_rd = 1'b1;
        bad_insn  = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        o_imm = imm_b;
        case (funct3)
          3'b000:  o_branch = BR_EQ;
          3'b001:  o_branch = BR_NE;
          3'b100:  o_branch = BR_LT;
          3'b101:  o_branch = BR_GE;
          3'b110:  o_branch = BR_LTU;
          3'b111:  o_branch = BR_GEU;
          default: bad_insn = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        o_src_b_imm = 1'b1;
        writes_rd   = 1'b1;
        case (funct3)
          3'b000: o_alu_op = ALU_ADD;
          3'b010: o_alu_op = ALU_SLT;
          3'b011: o_alu_op = ALU_SLTU;
          3'b100: o_alu_op = ALU_XOR;
          3'b110: o_alu_op = ALU_OR;
          3'b111: o_alu_op = ALU_AND;
          3'b001: begin
            o_alu_op = ALU_SLL;
            bad_insn = (funct7 != 7'h00);
          end
          default: begin // Shift right, funct7 picks the fill
            if (funct7 == 7'h00) begin
              o_alu_op = ALU_SRL;
            end else if (funct7 == 7'h20) begin
              o_alu_op = ALU_SRA;
            end else begin
              bad_insn = 1'b1;
            end
          end
        endcase
      end
      OPC_OP: begin
        writes_rd = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: o_alu_op = ALU_ADD;
          {7'h20, 3'b000}: o_alu_op = ALU_SUB;
          {7'h00, 3'b001}: o_alu_op = ALU_SLL;
          {7'h00, 3'b010}: o_alu_op = ALU_SLT;
          {7'h00, 3'b011}: o_alu_op = ALU_SLTU;
          {7'h00, 3'b100}: o_alu_op = ALU_XOR;
          {7'h00, 3'b101}: o_alu_op = ALU_SRL;
          {7'h20, 3'b101}: o_alu_op = ALU_SRA;
          {7'h00, 3'b110}: o_alu_op = ALU_OR;
          {7'h00, 3'b111}: o_alu_op = ALU_AND;
          default:         bad_insn = 1'b1; // M extension lands here too
        endcase
      end
      OPC_MISC_MEM: begin
        bad_insn = (funct3 != 3'b000); // Plain FENCE is a no-op
      end
      OPC_SYSTEM: begin
        if (i_insn[31:7] == 25'd0) begin
          o_halt_req = 1'b1; // ECALL
        end else begin
          bad_insn = 1'b1;
        end
      end
      default: bad_insn = 1'b1; // Loads, stores, unknown opcodes
    endcase
  end

  assign o_wb_en   = writes_rd && !bad_insn && !i_halted && (o_rd != '0);
  assign o_illegal = bad_insn && !i_halted;

endmodule

// File: hw/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_regfile (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_we,
  input  logic [`REG_ADDR_W-1:0] i_rd,
  input  logic [`XLEN-1:0]       i_rd_data,
  input  logic [`REG_ADDR_W-1:0] i_rs1,
  input  logic [`REG_ADDR_W-1:0] i_rs2,
  output logic [`XLEN-1:0]       o_rs1_data,
  output logic [`XLEN-1:0]       o_rs2_data
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int idx = 0; idx < `NUM_REGS; idx++) begin
        regs[idx] <= '0;
      end
    end else if (i_we && i_rd != '0) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  // x0 reads as zero whatever the array holds
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

  // Decoder must already have dropped writes to x0
  assert property (@(posedge clk) disable iff (rst) !(i_we && i_rd == '0));

endmodule

// File: hw/rv_alu.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_alu
  import rv_pkg::*;
(
  input  alu_op_e          i_op,
  input  logic [`XLEN-1:0] i_a,
  input  logic [`XLEN-1:0] i_b,
  output logic [`XLEN-1:0] o_result
);

  logic [4:0]       shamt;
  logic             lt_signed;
  logic             lt_unsigned;
  logic [`XLEN-1:0] sum;
  logic [`XLEN-1:0] diff;

  assign shamt = i_b[4:0]; // Only five bits count in RV32

  assign sum  = i_a + i_b;
  assign diff = i_a - i_b;

  // The two compares differ only when the sign bits differ
  assign lt_signed   = $signed(i_a) < $signed(i_b);
  assign lt_unsigned = i_a < i_b;

  always_comb begin
    case (i_op)
      ALU_ADD:  o_result = sum;
      ALU_SUB:  o_result = diff;
      ALU_SLL:  o_result = i_a << shamt;
      ALU_SLT:  o_result = {{(`XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: o_result = {{(`XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:  o_result = i_a ^ i_b;
      ALU_SRL:  o_result = i_a >> shamt;
      ALU_SRA:  o_result = $unsigned($signed(i_a) >>> shamt); // Sign fill
      ALU_OR:   o_result = i_a | i_b;
      ALU_AND:  o_result = i_a & i_b;
      default:  o_result = sum;
    endcase
  end

endmodule

// File: hw/rv_pc_unit.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_pc_unit
  import rv_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  branch_cond_e     i_cond,
  input  logic [`XLEN-1:0] i_rs1_data,
  input  logic [`XLEN-1:0] i_rs2_data,
  input  logic [`XLEN-1:0] i_imm,
  input  logic             i_halt_req,
  output logic [`XLEN-1:0] o_pc,
  output logic [`XLEN-1:0] o_link,
  output logic             o_halted
);

  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] pc_next;
  logic [`XLEN-1:0] pc_seq;
  logic [`XLEN-1:0] target_rel;
  logic [`XLEN-1:0] jalr_sum;
  logic             halted_q;
  logic             taken;

  assign pc_seq     = pc_q + `XLEN'(`INSN_BYTES);
  assign target_rel = pc_q + i_imm;     // Branches and JAL
  assign jalr_sum   = i_rs1_data + i_imm;

  always_comb begin
    case (i_cond)
      BR_EQ:       taken = (i_rs1_data == i_rs2_data);
      BR_NE:       taken = (i_rs1_data != i_rs2_data);
      BR_LT:       taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
      BR_GE:       taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      BR_LTU:      taken = (i_rs1_data < i_rs2_data);
      BR_GEU:      taken = (i_rs1_data >= i_rs2_data);
      BR_JUMP:     taken = 1'b1;
      BR_JUMP_REG: taken = 1'b1;
      default:     taken = 1'b0;
    endcase
  end

  always_comb begin
    if (i_cond == BR_JUMP_REG) begin
      pc_next = {jalr_sum[`XLEN-1:1], 1'b0}; // JALR drops bit 0
    end else if (taken) begin
      pc_next = target_rel;
    end else begin
      pc_next = pc_seq;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q     <= `XLEN'(`RESET_PC);
      halted_q <= 1'b0;
    end else begin
      if (!halted_q) begin
        pc_q <= pc_next;
      end
      if (i_halt_req) begin
        halted_q <= 1'b1; // Sticky until reset
      end
    end
  end

  assign o_pc     = pc_q;
  assign o_link   = pc_seq;
  assign o_halted = halted_q;

  assert property (@(posedge clk) disable iff (rst) o_pc[1:0] == 2'b00);

endmodule

// File: hw/rv_core.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core
  import rv_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`XLEN-1:0]       i_insn,
  output logic [`XLEN-1:0]       o_pc,
  output logic                   o_wb_en,
  output logic [`REG_ADDR_W-1:0] o_wb_rd,
  output logic [`XLEN-1:0]       o_wb_data,
  output logic                   o_illegal,
  output logic                   o_halt
);

  logic [`REG_ADDR_W-1:0] rs1;
  logic [`REG_ADDR_W-1:0] rs2;
  logic [`REG_ADDR_W-1:0] rd;
  logic [`XLEN-1:0]       imm;
  alu_op_e                alu_op;
  logic                   src_b_imm;
  logic                   src_a_pc;
  branch_cond_e           branch;
  wb_sel_e                wb_sel;
  logic                   wb_en;
  logic                   halt_req;
  logic                   halted;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;
  logic [`XLEN-1:0]       alu_a;
  logic [`XLEN-1:0]       alu_b;
  logic [`XLEN-1:0]       alu_result;
  logic [`XLEN-1:0]       link;
  logic [`XLEN-1:0]       pc;
  logic [`XLEN-1:0]       wb_data;

  rv_decoder u_decoder (
    .i_insn      (i_insn),
    .i_halted    (halted),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .o_rd        (rd),
    .o_imm       (imm),
    .o_alu_op    (alu_op),
    .o_src_b_imm (src_b_imm),
    .o_src_a_pc  (src_a_pc),
    .o_branch    (branch),
    .o_wb_sel    (wb_sel),
    .o_wb_en     (wb_en),
    .o_halt_req  (halt_req),
    .o_illegal   (o_illegal)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .i_we       (wb_en),
    .i_rd       (rd),
    .i_rd_data  (wb_data),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  assign alu_a = src_a_pc ? pc : rs1_data;   // AUIPC takes the PC
  assign alu_b = src_b_imm ? imm : rs2_data;

  rv_alu u_alu (
    .i_op     (alu_op),
    .i_a      (alu_a),
    .i_b      (alu_b),
    .o_result (alu_result)
  );

  rv_pc_unit u_pc_unit (
    .clk        (clk),
    .rst        (rst),
    .i_cond     (branch),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .i_imm      (imm),
    .i_halt_req (halt_req),
    .o_pc       (pc),
    .o_link     (link),
    .o_halted   (halted)
  );

  always_comb begin
    case (wb_sel)
      WB_LINK: wb_data = link;
      WB_IMM:  wb_data = imm; // LUI
      default: wb_data = alu_result;
    endcase
  end

  // Commit trace mirrors the register file write port
  assign o_pc      = pc;
  assign o_wb_en   = wb_en;
  assign o_wb_rd   = rd;
  assign o_wb_data = wb_data;
  assign o_halt    = halted;

  // Once halted nothing retires and nothing is flagged
  assert property (@(posedge clk) disable iff (rst) o_halt |-> !o_wb_en && !o_illegal);

endmodule

// File: verification/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core_tb
  import rv_pkg::*;
();

  localparam logic [31:0] NOP = 32'h00000013; // ADDI x0, x0, 0

  logic                   clk = 1'b0;
  logic                   rst;
  logic [`XLEN-1:0]       i_insn;
  logic [`XLEN-1:0]       o_pc;
  logic                   o_wb_en;
  logic [`REG_ADDR_W-1:0] o_wb_rd;
  logic [`XLEN-1:0]       o_wb_data;
  logic                   o_illegal;
  logic                   o_halt;

  logic [31:0] shadow_regs [`NUM_REGS];
  logic [31:0] shadow_pc;
  logic [31:0] lfsr_state = 32'd71999;
  int          checks = 0;
  int          errors = 0;

  always #50 clk = ~clk;

  rv_core u_rv_core (
    .clk       (clk),
    .rst       (rst),
    .i_insn    (i_insn),
    .o_pc      (o_pc),
    .o_wb_en   (o_wb_en),
    .o_wb_rd   (o_wb_rd),
    .o_wb_data (o_wb_data),
    .o_illegal (o_illegal),
    .o_halt    (o_halt)
  );

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) lfsr_state ^= 32'h80200003;
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input opcode_e opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input opcode_e opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input opcode_e opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic [31:0] reg_val(input logic [4:0] r);
    return (r == 5'd0) ? 32'd0 : shadow_regs[r];
  endfunction

  // Signed compare from the sign bits, unsigned compare otherwise
  function automatic logic signed_lt(input logic [31:0] a, input logic [31:0] b);
    return (a[31] != b[31]) ? a[31] : (a < b);
  endfunction

  function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    logic [4:0]  sh;
    logic [31:0] res;
    sh = b[4:0];
    case (f3)
      3'd0: res = alt ? a - b : a + b;
      3'd1: res = a << sh;
      3'd2: res = {31'd0, signed_lt(a, b)};
      3'd3: res = {31'd0, a < b};
      3'd4: res = a ^ b;
      3'd5: res = (a >> sh) | ((alt && a[31]) ? ~(32'hffffffff >> sh) : 32'h0);
      3'd6: res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  function automatic logic br_taken(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return signed_lt(a, b);
      3'd5:    return !signed_lt(a, b);
      3'd6:    return a < b;
      default: return !(a < b);
    endcase
  endfunction

  task automatic check_value(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      $display("[ERROR] %s: %s expected %h, actual %h", name, what, exp, act);
      errors++;
    end
  endtask

  // One instruction per cycle, trace sampled mid cycle
  task automatic exec(input string name, input logic [31:0] insn, input logic exp_we,
                      input logic [4:0] exp_rd, input logic [31:0] exp_data,
                      input logic exp_ill, input logic [31:0] exp_next_pc);
    @(posedge clk);
    i_insn <= insn;
    @(negedge clk);
    check_value(name, "o_pc", shadow_pc, o_pc);
    check_value(name, "o_wb_en", exp_we, o_wb_en);
    check_value(name, "o_illegal", exp_ill, o_illegal);
    if (exp_we) begin
      check_value(name, "o_wb_rd", exp_rd, o_wb_rd);
      check_value(name, "o_wb_data", exp_data, o_wb_data);
      shadow_regs[exp_rd] = exp_data;
    end
    shadow_pc = exp_next_pc;
  endtask

  task automatic exec_wr(input string name, input logic [31:0] insn, input logic [4:0] rd,
                         input logic [31:0] data);
    exec(name, insn, rd != 5'd0, rd, data, 1'b0, shadow_pc + 32'd4);
  endtask

  task automatic exec_nowr(input string name, input logic [31:0] insn,
                           input logic [31:0] next_pc);
    exec(name, insn, 1'b0, 5'd0, 32'd0, 1'b0, next_pc);
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    logic [19:0] upper;
    upper = value[31:12] + value[11]; // Undo the ADDI sign extension
    exec_wr("load_lui", enc_u(upper, rd, OPC_LUI), rd, {upper, 12'b0});
    exec_wr("load_addi", enc_i(value[11:0], rd, 3'b000, rd, OPC_OP_IMM), rd,
            model_alu(3'd0, 1'b0, reg_val(rd), sext12(value[11:0])));
  endtask

  task automatic test_reset_nop();
    check_value("reset", "o_pc", `RESET_PC, o_pc);
    check_value("reset", "o_halt", 32'd0, o_halt);
    check_value("reset", "o_wb_en", 32'd0, o_wb_en);
    shadow_pc = shadow_pc + 32'd4; // NOP held since reset retires on the first edge
    repeat (3) exec_nowr("nop", NOP, shadow_pc + 32'd4);
  endtask

  task automatic test_alu_ops();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [11:0] imm;
    logic [4:0]  sh;
    int          imm_f3 [6];
    imm_f3 = '{0, 2, 3, 4, 6, 7};
    for (int round = 0; round < 2; round++) begin
      a = rand_bits(32);
      b = rand_bits(32);
      if (round == 0) begin
        a[31] = 1'b1; // Negative vs positive splits SLT from SLTU
        b[31] = 1'b0;
      end
      load_reg(5'd1, a);
      load_reg(5'd2, b);
      foreach (imm_f3[i]) begin
        r   = rand_bits(12);
        imm = r[11:0];
        exec_wr("alu_imm", enc_i(imm, 5'd1, imm_f3[i], 5'd3, OPC_OP_IMM), 5'd3,
                model_alu(imm_f3[i], 1'b0, reg_val(5'd1), sext12(imm)));
      end
      for (int k = 0; k < 3; k++) begin
        r   = rand_bits(5);
        sh  = r[4:0];
        imm = {(k == 2) ? 7'h20 : 7'h00, sh}; // SLLI, SRLI, SRAI
        exec_wr("alu_shift_imm", enc_i(imm, 5'd1, (k == 0) ? 3'd1 : 3'd5, 5'd3, OPC_OP_IMM),
                5'd3, model_alu((k == 0) ? 3'd1 : 3'd5, k == 2, reg_val(5'd1), {27'd0, sh}));
      end
      for (int f3 = 0; f3 < 8; f3++) begin
        for (int alt = 0; alt < 2; alt++) begin
          if (alt == 0 || f3 == 0 || f3 == 5) begin
            exec_wr("alu_reg", enc_r(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd4, OPC_OP),
                    5'd4, model_alu(f3, alt, reg_val(5'd1), reg_val(5'd2)));
          end
        end
      end
    end
  endtask

  task automatic test_x0();
    exec_wr("x0_addi", enc_i(12'd5, 5'd1, 3'b000, 5'd0, OPC_OP_IMM), 5'd0, 32'd0);
    exec_wr("x0_lui", enc_u(20'habcde, 5'd0, OPC_LUI), 5'd0, 32'd0);
    exec_wr("x0_read", enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd5, OPC_OP), 5'd5, 32'd0);
    exec_wr("x0_read", enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd5, OPC_OP), 5'd5, reg_val(5'd1));
  endtask

  task automatic test_branches();
    logic [12:0] off;
    logic [20:0] joff;
    logic [11:0] imm;
    logic [31:0] target;
    logic [31:0] r;
    int          br_f3 [6];
    int          rs1s [3];
    int          rs2s [3];
    br_f3 = '{0, 1, 4, 5, 6, 7};
    rs1s  = '{6, 7, 6};
    rs2s  = '{7, 6, 6};
    load_reg(5'd6, 32'h80000000 | rand_bits(31)); // Negative operand
    load_reg(5'd7, rand_bits(31));
    foreach (br_f3[i]) begin
      for (int p = 0; p < 3; p++) begin
        r   = rand_bits(11);
        off = {r[10:0], 2'b00};
        exec_nowr("branch", enc_b(off, rs2s[p], rs1s[p], br_f3[i]),
                  br_taken(br_f3[i], reg_val(rs1s[p]), reg_val(rs2s[p])) ?
                  shadow_pc + {{19{off[12]}}, off} : shadow_pc + 32'd4);
      end
    end
    r    = rand_bits(19);
    joff = {r[18:0], 2'b00};
    exec("jal", enc_j(joff, 5'd8), 1'b1, 5'd8, shadow_pc + 32'd4, 1'b0,
         shadow_pc + {{11{joff[20]}}, joff});
    r = rand_bits(30);
    load_reg(5'd10, {r[29:0], 2'b00});
    r      = rand_bits(10);
    imm    = {r[9:0], 2'b01}; // Odd sum checks the bit 0 clear
    target = (reg_val(5'd10) + sext12(imm)) & ~32'd1;
    exec("jalr", enc_i(imm, 5'd10, 3'b000, 5'd9, OPC_JALR), 1'b1, 5'd9,
         shadow_pc + 32'd4, 1'b0, target);
  endtask

  task automatic test_auipc();
    logic [19:0] u;
    logic [31:0] r;
    repeat (2) begin
      r = rand_bits(20);
      u = r[19:0];
      exec_wr("auipc", enc_u(u, 5'd11, OPC_AUIPC), 5'd11, shadow_pc + {u, 12'b0});
    end
  endtask

  task automatic test_illegal_halt();
    int cycles;
    exec("illegal_f7", enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd12, OPC_OP), 1'b0, 5'd0,
         32'd0, 1'b1, shadow_pc + 32'd4);
    exec_nowr("fence", enc_i(12'h0ff, 5'd0, 3'b000, 5'd0, OPC_MISC_MEM), shadow_pc + 32'd4);
    exec_nowr("ecall", 32'h00000073, shadow_pc + 32'd4);
    cycles = 0;
    while (!o_halt && cycles < 8) begin
      @(negedge clk);
      cycles++;
    end
    assert (o_halt) else begin
      $display("Timed out waiting for o_halt after ECALL");
      errors++;
    end
    check_value("ecall", "halt latency", 32'd1, cycles);
    // PC frozen, nothing retires, nothing flagged
    exec_nowr("halted", enc_i(12'h123, 5'd0, 3'b000, 5'd1, OPC_OP_IMM), shadow_pc);
    exec_nowr("halted", enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd12, OPC_OP), shadow_pc);
    exec_nowr("halted", enc_u(20'h12345, 5'd3, OPC_LUI), shadow_pc);
    check_value("halted", "o_halt", 32'd1, o_halt);
  endtask

  initial begin
    rst    = 1'b1;
    i_insn = NOP;
    for (int i = 0; i < `NUM_REGS; i++) shadow_regs[i] = '0;
    shadow_pc = `RESET_PC;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    test_reset_nop();
    test_alu_ops();
    test_x0();
    test_branches();
    test_auipc();
    test_illegal_halt();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+hw
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_pc_unit.sv
hw/rv_core.sv
verification/rv_core_tb.sv
